//--- design/gpuPkg.sv
package gpuPkg;

  ////////////////////////////////////////
  // widths
  localparam int DataW   = 16;  // register and operand width
  localparam int PcW     = 8;   // microcode address
  localparam int FbAddrW = 13;  // frame buffer word counter
  localparam int LitW    = 10;  // literal field of a micro-op

  // video memory map
  localparam logic [15:0] MapBase0         = 16'h9800;  // lcdc[6] = 0
  localparam logic [15:0] MapBase1         = 16'h9c00;  // lcdc[6] = 1
  localparam logic [15:0] TileBaseUnsigned = 16'h8000;  // tiles 0..255
  localparam logic [15:0] TileBaseSigned   = 16'h9000;  // tiles -128..127

  // host register select codes
  localparam logic [3:0] McuSelLcdc = 4'd0;
  localparam logic [3:0] McuSelBgp  = 4'd7;

  localparam int TilesPerRow = 32;
  localparam int RowsPerTile = 8;

  // program labels
  localparam logic [PcW-1:0] PcStart    = 8'd0;
  localparam logic [PcW-1:0] PcTileLoop = 8'd1;
  localparam logic [PcW-1:0] PcRowLoop  = 8'd6;

  // jump kind carried in result[1:0] of a jump op
  // bit 1 marks a conditional jump, bit 0 the flag value that takes it
  localparam logic [1:0] JmpAlways    = 2'b00;
  localparam logic [1:0] JmpIfNotZero = 2'b10;
  localparam logic [1:0] JmpIfZero    = 2'b11;

  ////////////////////////////////////////
  // types
  typedef enum logic [4:0] {
    opNop = 5'd0, opWbg, opWrr, opWrl, opRvmem, opAdd, opShl,
    opAddl, opSubl, opSub, opJnz, opJz, opGoto, opAnd
  } gpuOp_t;

  typedef enum logic [4:0] {
    regLcdc = 5'd0, regBgp, regMcuAddr, regBh, regBl, regTile, regTileRow,
    regTileAddr, srcReadData, srcMapOffset, srcTileOffset, srcTileNumX16, srcZero
  } regIdx_t;

  typedef struct packed {
    gpuOp_t          op;
    regIdx_t         dst;
    regIdx_t         src0;
    regIdx_t         src1;
    logic [LitW-1:0] literal;  // jump target in [7:0]
  } uop_t;

  typedef struct packed {
    logic        readRequest;
    logic [15:0] addr;
  } mcuReq_t;

  typedef struct packed {
    logic        we;
    logic [15:0] addr;
    logic [15:0] data;
  } fbWrite_t;

  typedef struct packed {
    logic [DataW-1:0] result;
    logic             regWe;
    logic             jump;         // any jump op, condition sits in result
    logic             readRequest;
    logic             bgWe;
  } aluCtl_t;

endpackage

//--- design/gpuUcodeRom.sv
`timescale 1ns/1ps

module gpuUcodeRom (
  input  logic [gpuPkg::PcW-1:0] pc,
  output gpuPkg::uop_t           uop
);
  import gpuPkg::*;

  ////////////////////////////////////////
  // background program, one map row of tiles
  // op fields are op, dst, src0, src1, literal
  // add/sub/and take src1 op src0, literal ops work on src1
  always_comb
  begin
    case (pc)
      // start of a map row
      PcStart:
        uop = '{opWrl, regTile, srcZero, srcZero, 10'd0};  // tile = 0

      // per tile, fetch tile number from the map
      PcTileLoop:
        uop = '{opAdd, regMcuAddr, srcMapOffset, regTile, 10'd0};
      8'd2:  uop = '{opRvmem, srcZero, srcZero, srcZero, 10'd0};  // map read
      8'd3:  uop = '{opNop, srcZero, srcZero, srcZero, 10'd0};    // byte lands
      8'd4:  uop = '{opAdd, regTileAddr, srcTileOffset, srcTileNumX16, 10'd0};
      8'd5:  uop = '{opWrl, regTileRow, srcZero, srcZero, 10'd0};   // row = 0

      // per row, two bitplane bytes then one frame buffer word
      PcRowLoop:
        uop = '{opAdd, regMcuAddr, regTileAddr, regTileRow, 10'd0};
      8'd7:  uop = '{opRvmem, srcZero, srcZero, srcZero, 10'd0};    // low plane
      8'd8:  uop = '{opWrr, regBl, srcZero, srcReadData, 10'd0};
      8'd9:  uop = '{opAddl, regMcuAddr, srcZero, regMcuAddr, 10'd1};
      8'd10: uop = '{opRvmem, srcZero, srcZero, srcZero, 10'd0};    // high plane
      8'd11: uop = '{opWrr, regBh, srcZero, srcReadData, 10'd0};
      8'd12: uop = '{opWbg, srcZero, srcZero, srcZero, 10'd0};      // emit 8 pixels
      8'd13: uop = '{opAddl, regTileRow, srcZero, regTileRow, 10'd2};

      // row count check, result dropped, only the flag moves
      8'd14:
        uop = '{opSubl, srcZero, srcZero, regTileRow, 10'(2 * RowsPerTile)};
      8'd15:
        uop = '{opJnz, srcZero, srcZero, srcZero, 10'(PcRowLoop)};

      // next tile
      8'd16: uop = '{opAddl, regTile, srcZero, regTile, 10'd1};
      8'd17:
        uop = '{opSubl, srcZero, srcZero, regTile, 10'(TilesPerRow)};
      8'd18:
        uop = '{opJnz, srcZero, srcZero, srcZero, 10'(PcTileLoop)};

      // wrap to tile 0
      8'd19:
        uop = '{opGoto, srcZero, srcZero, srcZero, 10'(PcStart)};

      default:
        uop = '{opNop, srcZero, srcZero, srcZero, 10'd0};  // empty rom space
    endcase
  end

endmodule

//--- design/gpuSequencer.sv
`timescale 1ns/1ps

module gpuSequencer (
  input  logic                   iClock,
  input  logic                   rstN,
  input  logic                   active,  // lcdc[7]
  input  gpuPkg::aluCtl_t        aluCtl,
  input  logic [gpuPkg::PcW-1:0] target,
  output logic [gpuPkg::PcW-1:0] pc
);
  import gpuPkg::*;

  logic       zero;     // last written result was 0
  logic [1:0] jmpKind;  // goto, jz or jnz
  logic       taken;

  ////////////////////////////////////////
  // jump condition
  assign jmpKind = aluCtl.result[1:0];
  assign taken = aluCtl.jump &
                 ((jmpKind == JmpAlways) |
                  ((jmpKind == JmpIfZero) & zero) |
                  ((jmpKind == JmpIfNotZero) & ~zero));

  // program counter
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      pc <= '0;
    else if (!active)
      pc <= '0;           // engine off, restart from the top
    else if (taken)
      pc <= target;       // target runs next cycle
    else
      pc <= pc + 1'b1;
  end

  // zero flag follows every register write
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      zero <= 1'b0;
    else if (aluCtl.regWe)
      zero <= (aluCtl.result == '0);
  end

endmodule

//--- design/gpuRegFile.sv
`timescale 1ns/1ps

module gpuRegFile (
  input  logic                     iClock,
  input  logic                     rstN,
  input  logic [3:0]               mcuRegSelect,
  input  logic [7:0]               mcuWriteData,
  input  logic                     mcuWe,
  input  logic [7:0]               mcuReadData,
  input  gpuPkg::uop_t             uop,
  input  gpuPkg::aluCtl_t          aluCtl,
  output logic [gpuPkg::DataW-1:0] op0,
  output logic [gpuPkg::DataW-1:0] op1,
  output logic [7:0]               lcdc,
  output logic [7:0]               bgp,
  output logic [7:0]               bh,
  output logic [7:0]               bl,
  output logic [15:0]              mcuAddr
);
  import gpuPkg::*;

  logic [DataW-1:0] tile;        // tile index within the map row
  logic [DataW-1:0] tileRow;     // byte offset of the row, 2 per row
  logic [DataW-1:0] tileAddr;    // base of the current tile's data
  logic [DataW-1:0] mapOffset;
  logic [DataW-1:0] tileOffset;
  logic [DataW-1:0] tileNumX16;

  ////////////////////////////////////////
  // host registers
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      lcdc <= '0;
      bgp  <= '0;
    end
    else if (mcuWe)
    begin
      if (mcuRegSelect == McuSelLcdc)
        lcdc <= mcuWriteData;
      if (mcuRegSelect == McuSelBgp)
        bgp <= mcuWriteData;  // other selects fall through
    end
  end

  ////////////////////////////////////////
  // engine registers, written by the alu
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      mcuAddr  <= '0;
      bh       <= '0;
      bl       <= '0;
      tile     <= '0;
      tileRow  <= '0;
      tileAddr <= '0;
    end
    else if (aluCtl.regWe)
    begin
      case (uop.dst)
        regMcuAddr:  mcuAddr  <= aluCtl.result;
        regBh:       bh       <= aluCtl.result[7:0];
        regBl:       bl       <= aluCtl.result[7:0];
        regTile:     tile     <= aluCtl.result;
        regTileRow:  tileRow  <= aluCtl.result;
        regTileAddr: tileAddr <= aluCtl.result;
        default:     ;  // host regs and sources are read only
      endcase
    end
  end

  ////////////////////////////////////////
  // derived address sources
  assign mapOffset  = lcdc[6] ? MapBase1 : MapBase0;
  // signed set maps tiles 0x80..0xff down to 0x8800
  assign tileOffset = (lcdc[4] | mcuReadData[7]) ? TileBaseUnsigned : TileBaseSigned;
  assign tileNumX16 = {4'h0, mcuReadData, 4'h0};  // 16 bytes per tile

  // operand mux, shared by both selectors
  function automatic logic [DataW-1:0] selSrc(input regIdx_t idx);
    logic [DataW-1:0] val;
    case (idx)
      regLcdc:       val = {8'h00, lcdc};
      regBgp:        val = {8'h00, bgp};
      regMcuAddr:    val = mcuAddr;
      regBh:         val = {8'h00, bh};
      regBl:         val = {8'h00, bl};
      regTile:       val = tile;
      regTileRow:    val = tileRow;
      regTileAddr:   val = tileAddr;
      srcReadData:   val = {8'h00, mcuReadData};
      srcMapOffset:  val = mapOffset;
      srcTileOffset: val = tileOffset;
      srcTileNumX16: val = tileNumX16;
      default:       val = '0;  // srcZero
    endcase
    return val;
  endfunction

  always_comb
  begin
    op0 = selSrc(uop.src0);
    op1 = selSrc(uop.src1);
  end

endmodule

//--- design/gpuAlu.sv
`timescale 1ns/1ps

module gpuAlu (
  input  gpuPkg::uop_t             uop,
  input  logic [gpuPkg::DataW-1:0] op0,
  input  logic [gpuPkg::DataW-1:0] op1,
  output gpuPkg::aluCtl_t          aluCtl
);
  import gpuPkg::*;

  logic [DataW-1:0] lit;  // zero extended literal

  assign lit = DataW'(uop.literal);

  ////////////////////////////////////////
  // decode and execute
  always_comb
  begin
    aluCtl        = '0;   // no strobes unless the op asks
    aluCtl.result = lit;
    case (uop.op)
      opNop:   aluCtl.result = lit;               // idle slot
      opWbg:   aluCtl.bgWe = 1'b1;                // push pixels out
      opRvmem: aluCtl.readRequest = 1'b1;         // addr from mcuAddr reg
      opWrr:
      begin
        aluCtl.result = op1;                      // register move
        aluCtl.regWe  = 1'b1;
      end
      opWrl:   aluCtl.regWe = 1'b1;               // literal load
      opAdd:
      begin
        aluCtl.result = op1 + op0;
        aluCtl.regWe  = 1'b1;
      end
      opSub:
      begin
        aluCtl.result = op1 - op0;
        aluCtl.regWe  = 1'b1;
      end
      opShl:
      begin
        aluCtl.result = op1 << uop.literal[3:0];
        aluCtl.regWe  = 1'b1;
      end
      opAddl:
      begin
        aluCtl.result = op1 + lit;
        aluCtl.regWe  = 1'b1;
      end
      opSubl:
      begin
        aluCtl.result = op1 - lit;                // also feeds the zero flag
        aluCtl.regWe  = 1'b1;
      end
      opAnd:
      begin
        aluCtl.result = op1 & op0;
        aluCtl.regWe  = 1'b1;
      end
      // jumps only tag their kind, sequencer owns the flag
      opJnz:
      begin
        aluCtl.result = DataW'(JmpIfNotZero);
        aluCtl.jump   = 1'b1;
      end
      opJz:
      begin
        aluCtl.result = DataW'(JmpIfZero);
        aluCtl.jump   = 1'b1;
      end
      opGoto:
      begin
        aluCtl.result = DataW'(JmpAlways);
        aluCtl.jump   = 1'b1;
      end
      default: aluCtl.result = 16'hdead;          // bad opcode marker
    endcase
  end

endmodule

//--- design/bgPixelWriter.sv
`timescale 1ns/1ps

module bgPixelWriter (
  input  logic              iClock,
  input  logic              rstN,
  input  logic              bgWe,
  input  logic [7:0]        bh,   // high bitplane
  input  logic [7:0]        bl,   // low bitplane
  input  logic [7:0]        bgp,  // 4 x 2-bit palette
  output gpuPkg::fbWrite_t  fbWrite
);
  import gpuPkg::*;

  logic [FbAddrW-1:0] fbAddr;        // word counter, wraps
  logic [1:0]         colorIdx [8];  // raw color per pixel
  logic [15:0]        pixels;

  ////////////////////////////////////////
  // palette lookup, 8 pixels in parallel
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      colorIdx[i]      = {bh[i], bl[i]};
      pixels[2*i +: 2] = bgp[{colorIdx[i], 1'b0} +: 2];  // pixel 7 ends up on top
    end
  end

  // one step per word written, lcdc has no say here
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      fbAddr <= '0;
    else if (bgWe)
      fbAddr <= fbAddr + 1'b1;
  end

  assign fbWrite = '{we:   bgWe,
                     addr: {{(16 - FbAddrW){1'b0}}, fbAddr},
                     data: pixels};

endmodule

//--- design/gpu.sv
`timescale 1ns/1ps

module gpu (
  input  logic              iClock,
  input  logic              rstN,
  input  logic [3:0]        mcuRegSelect,  // host register select
  input  logic [7:0]        mcuWriteData,
  input  logic              mcuWe,
  input  logic [7:0]        mcuReadData,   // video memory byte
  output gpuPkg::mcuReq_t   mcuBus,
  output gpuPkg::fbWrite_t  fbWrite,
  output logic [7:0]        lcdc,
  output logic [7:0]        bgp
);
  import gpuPkg::*;

  logic [PcW-1:0]   pc;
  uop_t             uopRom;   // straight from the rom
  uop_t             uop;      // what the engine executes
  logic [DataW-1:0] op0;
  logic [DataW-1:0] op1;
  aluCtl_t          aluCtl;
  logic [7:0]       bh;
  logic [7:0]       bl;
  logic [15:0]      mcuAddr;

  ////////////////////////////////////////
  // engine runs only with lcdc[7] set, otherwise nops
  assign uop = lcdc[7] ? uopRom : '0;

  gpuSequencer uSeq (
    .iClock (iClock),
    .rstN   (rstN),
    .active (lcdc[7]),
    .aluCtl (aluCtl),
    .target (uop.literal[PcW-1:0]),
    .pc     (pc)
  );

  gpuUcodeRom uRom (
    .pc  (pc),
    .uop (uopRom)
  );

  gpuRegFile uRegs (
    .iClock (iClock), .rstN (rstN),
    .mcuRegSelect (mcuRegSelect), .mcuWriteData (mcuWriteData),
    .mcuWe (mcuWe), .mcuReadData (mcuReadData),
    .uop (uop), .aluCtl (aluCtl),
    .op0 (op0), .op1 (op1),
    .lcdc (lcdc), .bgp (bgp), .bh (bh), .bl (bl),
    .mcuAddr (mcuAddr)
  );

  gpuAlu uAlu (
    .uop    (uop),
    .op0    (op0),
    .op1    (op1),
    .aluCtl (aluCtl)
  );

  bgPixelWriter uPix (
    .iClock (iClock), .rstN (rstN),
    .bgWe (aluCtl.bgWe),
    .bh (bh), .bl (bl), .bgp (bgp),
    .fbWrite (fbWrite)
  );

  // video memory request, address comes from the register
  assign mcuBus = '{readRequest: aluCtl.readRequest, addr: mcuAddr};

endmodule

//--- sim/gpu_checker.sv
`timescale 1ns/1ps

module gpuChecker (
  input logic             iClock,
  input logic             rstN,
  input gpuPkg::mcuReq_t  mcuBus,
  input gpuPkg::fbWrite_t fbWrite,
  input logic [7:0]       lcdc,
  input logic [7:0]       bgp
);

  int failCount = 0;  // summed into the closing line

  ////////////////////////////////////////
  // bus usage
  noReadWithWrite: assert property (@(posedge iClock) disable iff (!rstN)
    !(mcuBus.readRequest && fbWrite.we))
    else begin failCount++; $error("read request and frame buffer write together"); end

  writeNeedsEnable: assert property (@(posedge iClock) disable iff (!rstN)
    fbWrite.we |-> lcdc[7])  // engine off means no pixels
    else begin failCount++; $error("frame buffer write with lcdc[7] clear"); end

  // strobes are single cycle pulses
  requestOneCycle: assert property (@(posedge iClock) disable iff (!rstN)
    mcuBus.readRequest |=> !mcuBus.readRequest)
    else begin failCount++; $error("read request longer than one cycle"); end

  writeOneCycle: assert property (@(posedge iClock) disable iff (!rstN)
    fbWrite.we |=> !fbWrite.we)
    else begin failCount++; $error("frame buffer write longer than one cycle"); end

  // no x or z leaves the dut once out of reset
  outputsKnown: assert property (@(posedge iClock) disable iff (!rstN)
    !$isunknown({mcuBus, fbWrite, lcdc, bgp}))
    else begin failCount++; $error("unknown value on a dut output"); end

endmodule

bind gpu gpuChecker chk (
  .iClock (iClock), .rstN (rstN), .mcuBus (mcuBus),
  .fbWrite (fbWrite), .lcdc (lcdc), .bgp (bgp)
);

//--- sim/gpuTb.sv
`timescale 1ns/1ps

module gpuTb;
  import gpuPkg::*;

  localparam int ClkPeriod  = 8;
  localparam int StepLimit  = 32;                       // cycles allowed between bus events
  localparam int TileCycles = 5 + RowsPerTile * 10 + 3; // map fetch, rows, tile count
  localparam int PassCycles = TilesPerRow * TileCycles + 2;
  localparam int WatchdogCycles = 2 * PassCycles + 1500;

  logic       iClock;
  logic       rstN;
  logic [3:0] mcuRegSelect;
  logic [7:0] mcuWriteData;
  logic       mcuWe;
  logic [7:0] mcuReadData;
  mcuReq_t    mcuBus;
  fbWrite_t   fbWrite;
  logic [7:0] lcdc;
  logic [7:0] bgp;

  logic [7:0]  vram [65536];  // video memory model
  mcuReq_t     sampledReq;    // request seen mid cycle
  int          errors = 0;
  int          testErrors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic [15:0] expFbAddr = '0;

  gpu dut (
    .iClock (iClock), .rstN (rstN), .mcuRegSelect (mcuRegSelect),
    .mcuWriteData (mcuWriteData), .mcuWe (mcuWe), .mcuReadData (mcuReadData),
    .mcuBus (mcuBus), .fbWrite (fbWrite), .lcdc (lcdc), .bgp (bgp)
  );

  initial
  begin
    iClock = 1'b0;
    forever #(ClkPeriod / 2) iClock = ~iClock;
  end

  ////////////////////////////////////////
  // request sampling and memory model
  always @(negedge iClock)
  begin
    sampledReq = mcuBus;
  end

  always @(posedge iClock)
  begin
    if (sampledReq.readRequest)
      mcuReadData <= vram[sampledReq.addr];  // held until the next request
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // tile data base with the signed set read as -128..127 around 0x9000
  function automatic logic [15:0] tileBase(input logic [7:0] num, input logic unsignedSet);
    logic [15:0] sx;
    sx = {{8{num[7]}}, num};
    if (unsignedSet)
      return TileBaseUnsigned + {4'h0, num, 4'h0};
    return TileBaseSigned + (sx << 4);
  endfunction

  function automatic logic [15:0] paletteWord(input logic [7:0] lo, input logic [7:0] hi,
                                              input logic [7:0] pal);
    logic [15:0] word;
    logic [7:0]  shifted;
    for (int i = 0; i < 8; i++)
    begin
      shifted = pal >> (2 * {hi[i], lo[i]});  // color index picks a 2-bit field
      word[2*i +: 2] = shifted[1:0];
    end
    return word;
  endfunction

  ////////////////////////////////////////
  // check helpers
  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      testErrors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic flagError(input string msg);
    errors++;
    testErrors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (testErrors != 0)
      testsFailed++;
    $display("test %-18s %s, %0d errors", name, (testErrors == 0) ? "passed" : "FAILED",
             testErrors);
    testErrors = 0;
  endtask

  task automatic writeHost(input logic [3:0] sel, input logic [7:0] data);
    @(posedge iClock);
    mcuRegSelect <= sel;
    mcuWriteData <= data;
    mcuWe        <= 1'b1;
    @(posedge iClock);
    mcuWe        <= 1'b0;  // register took the value at this edge
  endtask

  task automatic nextRequest(output logic [15:0] addr);
    int n;
    n = 0;
    do
    begin
      @(negedge iClock);
      n++;
      assert (!fbWrite.we) else flagError("frame buffer write where a read was expected");
    end while (!mcuBus.readRequest && n < StepLimit);
    assert (mcuBus.readRequest) else flagError("no read request within the step limit");
    addr = mcuBus.addr;
  endtask

  task automatic nextWrite();
    int n;
    n = 0;
    do
    begin
      @(negedge iClock);
      n++;
      assert (!mcuBus.readRequest) else flagError("read request where a write was expected");
    end while (!fbWrite.we && n < StepLimit);
    assert (fbWrite.we) else flagError("no frame buffer write within the step limit");
  endtask

  task automatic idleCheck(input int cycles);
    int reqs;
    int wrs;
    reqs = 0;
    wrs  = 0;
    repeat (cycles)
    begin
      @(negedge iClock);
      if (mcuBus.readRequest)
        reqs++;
      if (fbWrite.we)
        wrs++;
    end
    checkValue("read requests", 16'(reqs), 16'h0);
    checkValue("fb writes", 16'(wrs), 16'h0);
  endtask

  // restart the engine and follow nTiles tiles of one map row
  task automatic runPass(input logic [7:0] ctl, input logic [7:0] pal, input int nTiles);
    logic [15:0] addr;
    logic [15:0] mapAddr;
    logic [15:0] base;
    logic [7:0]  lo;
    logic [7:0]  hi;
    writeHost(McuSelLcdc, ctl & 8'h7f);  // engine off so pc returns to 0
    writeHost(McuSelBgp, pal);
    writeHost(McuSelLcdc, ctl);
    for (int t = 0; t < nTiles; t++)
    begin
      mapAddr = (ctl[6] ? MapBase1 : MapBase0) + 16'(t);
      nextRequest(addr);
      checkValue("mcuBus.addr", addr, mapAddr);
      base = tileBase(vram[mapAddr], ctl[4]);
      for (int r = 0; r < RowsPerTile; r++)
      begin
        nextRequest(addr);
        checkValue("mcuBus.addr", addr, base + 16'(2 * r));
        lo = vram[base + 16'(2 * r)];
        nextRequest(addr);
        checkValue("mcuBus.addr", addr, base + 16'(2 * r + 1));
        hi = vram[base + 16'(2 * r + 1)];
        nextWrite();
        checkValue("fbWrite.addr", fbWrite.addr, expFbAddr);
        checkValue("fbWrite.data", fbWrite.data, paletteWord(lo, hi, pal));
        expFbAddr = (expFbAddr + 1'b1) & 16'h1fff;  // 13-bit counter
      end
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  initial
  begin
    logic [31:0] seed;
    seed = 32'h7d51b03f;
    for (int a = 0; a < 65536; a++)
    begin
      seed = xorshift(seed);
      vram[a] = seed[7:0] ^ seed[23:16];
    end
    vram[MapBase1]     = 8'h05;  // positive tile for the signed set
    vram[MapBase1 + 1] = 8'h85;  // negative tile for the signed set
    sampledReq   = '0;
    rstN         = 1'b0;
    mcuRegSelect = '0;
    mcuWriteData = '0;
    mcuWe        = 1'b0;
    mcuReadData  = '0;
    repeat (4) @(posedge iClock);
    rstN <= 1'b1;

    @(negedge iClock);
    checkValue("fbWrite.we", 16'(fbWrite.we), 16'h0);
    checkValue("mcuBus.readRequest", 16'(mcuBus.readRequest), 16'h0);
    checkValue("lcdc", 16'(lcdc), 16'h0);
    checkValue("bgp", 16'(bgp), 16'h0);
    idleCheck(20);
    endTest("reset and idle");

    writeHost(McuSelBgp, 8'he4);
    writeHost(McuSelLcdc, 8'h50);   // engine stays off with bit 7 clear
    @(negedge iClock);
    checkValue("bgp", 16'(bgp), 16'h00e4);
    checkValue("lcdc", 16'(lcdc), 16'h0050);
    writeHost(4'd3, 8'hff);
    writeHost(4'd15, 8'hff);
    @(negedge iClock);
    checkValue("lcdc", 16'(lcdc), 16'h0050);
    checkValue("bgp", 16'(bgp), 16'h00e4);
    endTest("host registers");

    runPass(8'h90, 8'he4, TilesPerRow);  // map 0 with the unsigned set
    endTest("map0 unsigned");
    runPass(8'hc0, 8'h1b, TilesPerRow);  // map 1 with the signed set
    endTest("map1 signed");

    writeHost(McuSelLcdc, 8'h40);
    @(negedge iClock);
    checkValue("lcdc", 16'(lcdc), 16'h0040);
    idleCheck(40);
    runPass(8'h90, 8'he4, 2);            // tile 0 again while the fb address carries on
    endTest("stop and restart");

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             testsRun, testsFailed, errors, dut.chk.failCount);
    if (errors == 0 && dut.chk.failCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // two full passes plus setup and idle time
  initial
  begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, run stopped", WatchdogCycles);
    $display("Something failed");
    $finish;
  end

endmodule

//--- project.f
design/gpuPkg.sv
design/gpuUcodeRom.sv
design/gpuSequencer.sv
design/gpuRegFile.sv
design/gpuAlu.sv
design/bgPixelWriter.sv
design/gpu.sv
sim/gpu_checker.sv
sim/gpuTb.sv
